/* tlb_top.f */
+incdir+rtl
+incdir+testbench
rtl/tlb_pkg.sv
rtl/tlb_lutram.sv
rtl/tlb_match_stage.sv
rtl/tlb_select_stage.sv
rtl/tlb_inv_engine.sv
rtl/tlb_entry.sv
rtl/tlb_top.sv
testbench/tb_tlb_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tlb_top.f \
    --top-module tb_tlb_top \
    --Mdir obj_dir

./obj_dir/Vtb_tlb_top

/* testbench/tb_tlb_ref.svh */
`ifndef TB_TLB_REF_SVH
`define TB_TLB_REF_SVH

// model state, index = way * nset + set
tlb_entry_t  m_body [`TLB_NWAY * `TLB_NSET];
logic        m_valid [`TLB_NWAY * `TLB_NSET];
logic [31:0] lcg_state = 32'h53eb;

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// huge pages compare only vppn[18:9]
function automatic logic vpn_match(tlb_entry_t e, vppn_t vpn);
    if (e.ps == ps_t'(`TLB_PS_4K)) begin
        return e.vppn == vpn;
    end
    return e.vppn[18:9] == vpn[18:9];
endfunction

function automatic tlb_search_rsp_t model_lookup(tlb_search_req_t req);
    tlb_search_rsp_t rsp;
    tlb_idx_t        idx;
    tlb_entry_t      e;
    logic            odd;
    rsp = '0;
    for (int w = 0; w < `TLB_NWAY; w++) begin
        idx = tlb_idx_t'(w * `TLB_NSET) + tlb_idx_t'(req.vppn[10:8]);
        e   = m_body[idx];
        if (m_valid[idx] && vpn_match(e, req.vppn) && (e.g || e.asid == req.asid)) begin
            odd       = (e.ps == ps_t'(`TLB_PS_4K)) ? req.odd_page : req.vppn[8];
            rsp.found = 1'b1;  // later ways overwrite, highest wins
            rsp.index = idx;
            rsp.ps    = e.ps;
            rsp.page  = odd ? e.page1 : e.page0;
        end
    end
    return rsp;
endfunction

function automatic void model_invalidate(tlb_inv_t inv);
    logic asid_eq;
    logic hit;
    for (int i = 0; i < `TLB_NWAY * `TLB_NSET; i++) begin
        asid_eq = m_body[i].asid == inv.asid;
        case (inv.op)
            INV_ALL0, INV_ALL1: hit = 1'b1;
            INV_GLOBAL:         hit = m_body[i].g;
            INV_NONGLOBAL:      hit = !m_body[i].g;
            INV_ASID:           hit = !m_body[i].g && asid_eq;
            INV_ASID_VA:        hit = !m_body[i].g && asid_eq && vpn_match(m_body[i], inv.vpn);
            INV_GA_VA:          hit = (m_body[i].g || asid_eq) && vpn_match(m_body[i], inv.vpn);
            default:            hit = 1'b0;
        endcase
        if (hit) begin
            m_valid[i] = 1'b0;
        end
    end
endfunction

`endif

/* testbench/tb_tlb_top.sv */
`include "tlb_settings.svh"

module tb_tlb_top;
    import tlb_pkg::*;

    `include "tb_tlb_ref.svh"

    logic            clk = 1'b0;
    logic            arst_n;
    tlb_search_req_t s0_req;
    tlb_search_req_t s1_req;
    tlb_search_rsp_t s0_rsp;
    tlb_search_rsp_t s1_rsp;
    logic            we;
    tlb_idx_t        w_index;
    tlb_wr_port_t    w_entry;
    tlb_idx_t        r_index;
    tlb_wr_port_t    r_entry;
    tlb_inv_t        inv;
    logic            inv_stall;

    // expected values are checked only while their flag is up
    tlb_search_rsp_t exp_s0;
    tlb_search_rsp_t exp_s1;
    tlb_wr_port_t    exp_rd;
    logic            chk_srch = 1'b0;
    logic            chk_rd = 1'b0;

    always #4 clk = ~clk;

    tlb_top i_tlb_top (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .s0_req_i    (s0_req),
        .s1_req_i    (s1_req),
        .s0_rsp_o    (s0_rsp),
        .s1_rsp_o    (s1_rsp),
        .we_i        (we),
        .w_index_i   (w_index),
        .w_entry_i   (w_entry),
        .r_index_i   (r_index),
        .r_entry_o   (r_entry),
        .inv_i       (inv),
        .inv_stall_o (inv_stall)
    );

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s got %0h exp %0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    s0_rsp_check: assert property (@(posedge clk) !chk_srch || s0_rsp === exp_s0)
        else begin
            $display("CHECK FAILED t=%0t s0_rsp_o got %h exp %h", $time, s0_rsp, exp_s0);
            stop_on_error();
        end

    s1_rsp_check: assert property (@(posedge clk) !chk_srch || s1_rsp === exp_s1)
        else begin
            $display("CHECK FAILED t=%0t s1_rsp_o got %h exp %h", $time, s1_rsp, exp_s1);
            stop_on_error();
        end

    r_entry_check: assert property (@(posedge clk) !chk_rd || r_entry === exp_rd)
        else begin
            $display("CHECK FAILED t=%0t r_entry_o got %h exp %h", $time, r_entry, exp_rd);
            stop_on_error();
        end

    // small tag and asid pools so that searches hit often
    function automatic tlb_wr_port_t rand_entry(tlb_idx_t idx);
        tlb_wr_port_t ent;
        logic [31:0]  r;
        r = next_rand();
        ent.body.vppn  = {6'd0, r[31:30], idx[2:0], 6'd0, r[29:28]};
        ent.body.ps    = r[27] ? ps_t'(`TLB_PS_2M) : ps_t'(`TLB_PS_4K);
        ent.body.g     = r[26] & r[25];
        ent.body.asid  = asid_t'(r[24:23]);
        ent.e          = r[22:20] != 3'd0;
        r = next_rand();
        ent.body.page0 = tlb_page_t'(r[31:6]);
        r = next_rand();
        ent.body.page1 = tlb_page_t'(r[31:6]);
        return ent;
    endfunction

    function automatic tlb_wr_port_t make_entry(vppn_t vppn, ps_t ps, asid_t asid);
        tlb_wr_port_t ent;
        ent           = rand_entry(tlb_idx_t'(0));
        ent.body.vppn = vppn;
        ent.body.ps   = ps;
        ent.body.asid = asid;
        ent.body.g    = 1'b0;
        ent.e         = 1'b1;
        return ent;
    endfunction

    function automatic tlb_search_req_t rand_req();
        tlb_search_req_t req;
        logic [31:0]     r;
        r = next_rand();
        req.fetch = 1'b1;
        if (r[26:25] == 2'd0) begin
            req.vppn = {6'd0, r[24:23], r[22:20], 6'd0, r[19:18]};
        end else begin
            req.vppn = m_body[r[31:27]].vppn;
            req.vppn[0] = req.vppn[0] ^ r[17];  // misses a 4k page but not a 2m one
        end
        req.odd_page = r[16];
        req.asid     = asid_t'(r[15:14]);
        return req;
    endfunction

    task automatic write_entry(tlb_idx_t idx, tlb_wr_port_t ent);
        @(negedge clk);
        we           = 1'b1;
        w_index      = idx;
        w_entry      = ent;
        m_body[idx]  = ent.body;
        m_valid[idx] = ent.e;
        @(negedge clk);
        we = 1'b0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < `TLB_NWAY * `TLB_NSET; i++) begin
            write_entry(tlb_idx_t'(i), rand_entry(tlb_idx_t'(i)));
        end
    endtask

    task automatic check_reads();
        for (int i = 0; i < `TLB_NWAY * `TLB_NSET; i++) begin
            @(negedge clk);
            r_index     = tlb_idx_t'(i);
            exp_rd.body = m_body[i];
            exp_rd.e    = m_valid[i];
            chk_rd      = 1'b1;
        end
        @(negedge clk);
        chk_rd = 1'b0;
    endtask

    // response is checked on the two edges after the fetch edge
    task automatic search(tlb_search_req_t r0, tlb_search_req_t r1);
        @(negedge clk);
        chk_srch = 1'b0;
        s0_req   = r0;
        s1_req   = r1;
        exp_s0   = model_lookup(r0);
        exp_s1   = model_lookup(r1);
        @(negedge clk);
        s0_req.fetch = 1'b0;
        s1_req.fetch = 1'b0;
        s0_req.vppn  = ~s0_req.vppn;  // response must hold without fetch
        s1_req.asid  = ~s1_req.asid;
        chk_srch     = 1'b1;
        repeat (2) @(negedge clk);
    endtask

    task automatic run_inv(inv_op_e op);
        tlb_inv_t    cmd;
        logic [31:0] r;
        int          stall_cycles;
        r        = next_rand();
        cmd.en   = 1'b1;
        cmd.op   = op;
        cmd.vpn  = m_body[r[31:27]].vppn;
        cmd.asid = r[26] ? m_body[r[31:27]].asid : asid_t'(r[25:24]);
        @(negedge clk);
        inv          = cmd;
        stall_cycles = 0;
        #1;
        while (inv_stall) begin
            stall_cycles++;
            if (stall_cycles > 50) begin
                $display("timeout: inv_stall_o still high after 50 cycles");
                stop_on_error();
            end
            @(negedge clk);
            #1;
        end
        check_val("inv_stall_o high cycles", stall_cycles, `TLB_NSET);
        model_invalidate(cmd);
        @(negedge clk);
        inv.en = 1'b0;
    endtask

    initial begin
        tlb_search_req_t req;
        arst_n  = 1'b1;
        s0_req  = '0;
        s1_req  = '0;
        we      = 1'b0;
        w_index = '0;
        w_entry = '0;
        r_index = '0;
        inv     = '0;
        exp_s0  = '0;
        exp_s1  = '0;
        exp_rd  = '0;
        @(negedge clk);
        arst_n = 1'b0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        check_val("s0_rsp_o.found", 32'(s0_rsp.found), 32'd0);
        check_val("s1_rsp_o.found", 32'(s1_rsp.found), 32'd0);
        check_val("inv_stall_o", 32'(inv_stall), 32'd0);

        fill_random();
        check_reads();
        repeat (40) search(rand_req(), rand_req());

        // odd half comes from odd_page for 4k and from vppn[8] for 2m
        write_entry(tlb_idx_t'(2), make_entry(19'h40243, ps_t'(`TLB_PS_4K), 10'd1));
        write_entry(tlb_idx_t'(13), make_entry(19'h00540, ps_t'(`TLB_PS_2M), 10'd1));
        write_entry(tlb_idx_t'(20), make_entry(19'h004a0, ps_t'(`TLB_PS_2M), 10'd1));
        search(tlb_search_req_t'{1'b1, 19'h40243, 1'b0, 10'd1},
               tlb_search_req_t'{1'b1, 19'h40243, 1'b1, 10'd1});
        search(tlb_search_req_t'{1'b1, 19'h005ff, 1'b0, 10'd1},
               tlb_search_req_t'{1'b1, 19'h004b7, 1'b1, 10'd1});

        // same page in ways 1 and 3 of set 6
        write_entry(tlb_idx_t'(14), make_entry(19'h00612, ps_t'(`TLB_PS_4K), 10'd2));
        write_entry(tlb_idx_t'(30), make_entry(19'h00612, ps_t'(`TLB_PS_4K), 10'd2));
        req = tlb_search_req_t'{1'b1, 19'h00612, 1'b0, 10'd2};
        search(req, req);
        check_val("s0_rsp_o.index", 32'(s0_rsp.index), 32'd30);

        for (int op = 0; op < 7; op++) begin
            fill_random();
            run_inv(inv_op_e'(op));
            check_reads();
            repeat (8) search(rand_req(), rand_req());
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* rtl/tlb_top.sv */
`include "tlb_settings.svh"

module tlb_top (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  tlb_pkg::tlb_search_req_t s0_req_i,
    input  tlb_pkg::tlb_search_req_t s1_req_i,
    output tlb_pkg::tlb_search_rsp_t s0_rsp_o,
    output tlb_pkg::tlb_search_rsp_t s1_rsp_o,
    input  logic                     we_i,
    input  tlb_pkg::tlb_idx_t        w_index_i,
    input  tlb_pkg::tlb_wr_port_t    w_entry_i,
    input  tlb_pkg::tlb_idx_t        r_index_i,
    output tlb_pkg::tlb_wr_port_t    r_entry_o,
    input  tlb_pkg::tlb_inv_t        inv_i,
    output logic                     inv_stall_o
);
    import tlb_pkg::*;

    logic                 sweep_active;
    tlb_set_t             sweep_set;
    tlb_entry_t           sweep_ways [`TLB_NWAY];
    logic [`TLB_NWAY-1:0] clear_mask;

    tlb_entry i_tlb_entry (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .s0_req_i       (s0_req_i),
        .s1_req_i       (s1_req_i),
        .s0_rsp_o       (s0_rsp_o),
        .s1_rsp_o       (s1_rsp_o),
        .we_i           (we_i),
        .w_index_i      (w_index_i),
        .w_entry_i      (w_entry_i),
        .r_index_i      (r_index_i),
        .r_entry_o      (r_entry_o),
        .sweep_active_i (sweep_active),
        .sweep_set_i    (sweep_set),
        .clear_mask_i   (clear_mask),
        .sweep_ways_o   (sweep_ways)
    );

    // walks the sets and feeds the clear mask back
    tlb_inv_engine i_tlb_inv_engine (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .inv_i          (inv_i),
        .ways_i         (sweep_ways),
        .sweep_active_o (sweep_active),
        .sweep_set_o    (sweep_set),
        .clear_mask_o   (clear_mask),
        .stall_o        (inv_stall_o)
    );

endmodule

/* rtl/tlb_entry.sv */
`include "tlb_settings.svh"

module tlb_entry (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  tlb_pkg::tlb_search_req_t s0_req_i,
    input  tlb_pkg::tlb_search_req_t s1_req_i,
    output tlb_pkg::tlb_search_rsp_t s0_rsp_o,
    output tlb_pkg::tlb_search_rsp_t s1_rsp_o,
    input  logic                     we_i,
    input  tlb_pkg::tlb_idx_t        w_index_i,
    input  tlb_pkg::tlb_wr_port_t    w_entry_i,
    input  tlb_pkg::tlb_idx_t        r_index_i,
    output tlb_pkg::tlb_wr_port_t    r_entry_o,
    input  logic                     sweep_active_i,
    input  tlb_pkg::tlb_set_t        sweep_set_i,
    input  logic [`TLB_NWAY-1:0]     clear_mask_i,
    output tlb_pkg::tlb_entry_t      sweep_ways_o [`TLB_NWAY]
);
    import tlb_pkg::*;

    localparam int n_port = 2;  // inst, data

    logic [`TLB_NWAY-1:0][`TLB_NSET-1:0] valid_q;

    tlb_way_t w_way;
    tlb_set_t w_set;
    tlb_way_t r_way;
    tlb_set_t r_set;
    tlb_set_t m_addr;

    tlb_search_req_t      req [n_port];
    tlb_search_rsp_t      rsp [n_port];
    tlb_set_t             s_set [n_port];
    tlb_entry_t           s_ways [n_port][`TLB_NWAY];
    logic [`TLB_NWAY-1:0] s_valid [n_port];
    logic [`TLB_NWAY-1:0] m_hit [n_port];
    tlb_page_t            m_pages [n_port][`TLB_NWAY];
    ps_t                  m_ps [n_port][`TLB_NWAY];
    tlb_set_t             m_set [n_port];

    assign req[0]   = s0_req_i;
    assign req[1]   = s1_req_i;
    assign s0_rsp_o = rsp[0];
    assign s1_rsp_o = rsp[1];

    // upper index bits pick the way
    assign {w_way, w_set} = w_index_i;
    assign {r_way, r_set} = r_index_i;

    // maintenance read port is borrowed by the invtlb sweep
    assign m_addr = sweep_active_i ? sweep_set_i : r_set;

    for (genvar w = 0; w < `TLB_NWAY; w++) begin : g_way
        tlb_lutram i_tlb_lutram (
            .clk       (clk),
            .s0_addr_i (s_set[0]),
            .s1_addr_i (s_set[1]),
            .r_addr_i  (m_addr),
            .s0_data_o (s_ways[0][w]),
            .s1_data_o (s_ways[1][w]),
            .r_data_o  (sweep_ways_o[w]),
            .we_i      (we_i && (w_way == tlb_way_t'(w))),
            .w_addr_i  (w_set),
            .w_data_i  (w_entry_i.body)
        );
    end

    for (genvar p = 0; p < n_port; p++) begin : g_port
        assign s_set[p] = req[p].vppn[`TLB_SET_LSB +: $bits(tlb_set_t)];

        for (genvar w = 0; w < `TLB_NWAY; w++) begin : g_valid
            assign s_valid[p][w] = valid_q[w][s_set[p]];
        end

        tlb_match_stage i_tlb_match_stage (
            .clk         (clk),
            .arst_n_i    (arst_n_i),
            .req_i       (req[p]),
            .set_valid_i (s_valid[p]),
            .ways_i      (s_ways[p]),
            .hit_o       (m_hit[p]),
            .pages_o     (m_pages[p]),
            .ps_o        (m_ps[p]),
            .set_o       (m_set[p])
        );

        tlb_select_stage i_tlb_select_stage (
            .hit_i   (m_hit[p]),
            .pages_i (m_pages[p]),
            .ps_i    (m_ps[p]),
            .set_i   (m_set[p]),
            .rsp_o   (rsp[p])
        );
    end

    // not meaningful while a sweep owns the read address
    assign r_entry_o.body = sweep_ways_o[r_way];
    assign r_entry_o.e    = valid_q[r_way][r_set];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < `TLB_NWAY; w++) begin
                if (clear_mask_i[w]) begin
                    valid_q[w][sweep_set_i] <= 1'b0;
                end
            end
            // write comes last and so beats the clear
            if (we_i) begin
                valid_q[w_way][w_set] <= w_entry_i.e;
            end
        end
    end

endmodule

/* rtl/tlb_inv_engine.sv */
`include "tlb_settings.svh"

module tlb_inv_engine (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  tlb_pkg::tlb_inv_t    inv_i,
    input  tlb_pkg::tlb_entry_t  ways_i [`TLB_NWAY],
    output logic                 sweep_active_o,
    output tlb_pkg::tlb_set_t    sweep_set_o,
    output logic [`TLB_NWAY-1:0] clear_mask_o,
    output logic                 stall_o
);
    import tlb_pkg::*;

    localparam int vppn_msb = $bits(vppn_t) - 1;

    inv_state_e           state_q;
    inv_state_e           state_d;
    tlb_set_t             set_q;
    logic                 last_set;
    logic [`TLB_NWAY-1:0] op_hit;

    // set 0 is swept in the same cycle en first shows up
    assign sweep_active_o = (state_q == INV_SWEEP) || ((state_q == INV_IDLE) && inv_i.en);
    assign stall_o        = sweep_active_o;
    assign sweep_set_o    = set_q;
    assign last_set       = set_q == tlb_set_t'(`TLB_NSET - 1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            INV_IDLE: begin
                if (inv_i.en) begin
                    state_d = INV_SWEEP;
                end
            end
            INV_SWEEP: begin
                if (last_set) begin
                    state_d = inv_i.en ? INV_DONE : INV_IDLE;
                end
            end
            INV_DONE: begin
                if (!inv_i.en) begin
                    state_d = INV_IDLE;  // requester released
                end
            end
            default: begin
                state_d = INV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= INV_IDLE;
            set_q   <= '0;
        end else begin
            state_q <= state_d;
            if (sweep_active_o) begin
                set_q <= set_q + tlb_set_t'(1);  // wraps back to 0 after last set
            end
        end
    end

    // per way op rule on the entries read at set_q
    always_comb begin
        logic is_4k;
        logic asid_eq;
        logic va_eq;
        op_hit = '0;
        for (int w = 0; w < `TLB_NWAY; w++) begin
            is_4k   = ways_i[w].ps == ps_t'(`TLB_PS_4K);
            asid_eq = ways_i[w].asid == inv_i.asid;
            if (is_4k) begin
                va_eq = ways_i[w].vppn == inv_i.vpn;
            end else begin
                va_eq = ways_i[w].vppn[vppn_msb:`TLB_HUGE_LSB]
                        == inv_i.vpn[vppn_msb:`TLB_HUGE_LSB];
            end
            case (inv_i.op)
                INV_ALL0, INV_ALL1: op_hit[w] = 1'b1;
                INV_GLOBAL:         op_hit[w] = ways_i[w].g;
                INV_NONGLOBAL:      op_hit[w] = !ways_i[w].g;
                INV_ASID:           op_hit[w] = !ways_i[w].g && asid_eq;
                INV_ASID_VA:        op_hit[w] = !ways_i[w].g && asid_eq && va_eq;
                INV_GA_VA:          op_hit[w] = (ways_i[w].g || asid_eq) && va_eq;
                default:            op_hit[w] = 1'b0;  // reserved ops clear nothing
            endcase
        end
    end

    assign clear_mask_o = sweep_active_o ? op_hit : '0;

endmodule

/* rtl/tlb_select_stage.sv */
`include "tlb_settings.svh"

module tlb_select_stage (
    input  logic [`TLB_NWAY-1:0]     hit_i,
    input  tlb_pkg::tlb_page_t       pages_i [`TLB_NWAY],
    input  tlb_pkg::ps_t             ps_i [`TLB_NWAY],
    input  tlb_pkg::tlb_set_t        set_i,
    output tlb_pkg::tlb_search_rsp_t rsp_o
);
    import tlb_pkg::*;

    tlb_way_t way;

    always_comb begin
        rsp_o = '0;
        way   = '0;
        // ascending scan, last hit wins so the highest way is reported
        for (int w = 0; w < `TLB_NWAY; w++) begin
            if (hit_i[w]) begin
                way        = tlb_way_t'(w);
                rsp_o.ps   = ps_i[w];
                rsp_o.page = pages_i[w];
            end
        end
        rsp_o.found = |hit_i;
        rsp_o.index = rsp_o.found ? {way, set_i} : '0;  // way * nset + set
    end

endmodule

/* rtl/tlb_match_stage.sv */
`include "tlb_settings.svh"

module tlb_match_stage (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  tlb_pkg::tlb_search_req_t req_i,
    input  logic [`TLB_NWAY-1:0]     set_valid_i,
    input  tlb_pkg::tlb_entry_t      ways_i [`TLB_NWAY],
    output logic [`TLB_NWAY-1:0]     hit_o,
    output tlb_pkg::tlb_page_t       pages_o [`TLB_NWAY],
    output tlb_pkg::ps_t             ps_o [`TLB_NWAY],
    output tlb_pkg::tlb_set_t        set_o
);
    import tlb_pkg::*;

    localparam int vppn_msb = $bits(vppn_t) - 1;

    logic [`TLB_NWAY-1:0] hit_d;
    tlb_page_t            page_d [`TLB_NWAY];

    always_comb begin
        logic is_4k;
        logic tag_eq;
        logic odd;
        hit_d = '0;
        for (int w = 0; w < `TLB_NWAY; w++) begin
            is_4k = ways_i[w].ps == ps_t'(`TLB_PS_4K);
            // huge pages drop the low vppn bits from the tag
            if (is_4k) begin
                tag_eq = req_i.vppn == ways_i[w].vppn;
            end else begin
                tag_eq = req_i.vppn[vppn_msb:`TLB_HUGE_LSB]
                         == ways_i[w].vppn[vppn_msb:`TLB_HUGE_LSB];
            end
            odd = is_4k ? req_i.odd_page : req_i.vppn[`TLB_HUGE_LSB - 1];
            hit_d[w] = set_valid_i[w] && tag_eq
                       && (ways_i[w].g || (ways_i[w].asid == req_i.asid));
            page_d[w] = odd ? ways_i[w].page1 : ways_i[w].page0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hit_o <= '0;
        end else if (req_i.fetch) begin
            hit_o <= hit_d;
        end
    end

    // payload, only meaningful where hit_o is set
    always_ff @(posedge clk) begin
        if (req_i.fetch) begin
            for (int w = 0; w < `TLB_NWAY; w++) begin
                pages_o[w] <= page_d[w];
                ps_o[w]    <= ways_i[w].ps;
            end
            set_o <= req_i.vppn[`TLB_SET_LSB +: $bits(tlb_set_t)];
        end
    end

endmodule

/* rtl/tlb_lutram.sv */
`include "tlb_settings.svh"

module tlb_lutram (
    input  logic                 clk,
    input  tlb_pkg::tlb_set_t    s0_addr_i,
    input  tlb_pkg::tlb_set_t    s1_addr_i,
    input  tlb_pkg::tlb_set_t    r_addr_i,
    output tlb_pkg::tlb_entry_t  s0_data_o,
    output tlb_pkg::tlb_entry_t  s1_data_o,
    output tlb_pkg::tlb_entry_t  r_data_o,
    input  logic                 we_i,
    input  tlb_pkg::tlb_set_t    w_addr_i,
    input  tlb_pkg::tlb_entry_t  w_data_i
);
    import tlb_pkg::*;

    tlb_entry_t mem [`TLB_NSET];  // one way, distributed ram

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[w_addr_i] <= w_data_i;
        end
    end

    // async reads
    assign s0_data_o = mem[s0_addr_i];  // inst search
    assign s1_data_o = mem[s1_addr_i];  // data search
    assign r_data_o  = mem[r_addr_i];   // tlbrd or invtlb sweep

endmodule

/* rtl/tlb_pkg.sv */
`include "tlb_settings.svh"

package tlb_pkg;

    typedef logic [18:0] vppn_t;  // va[31:13]
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;

    typedef logic [$clog2(`TLB_NWAY * `TLB_NSET)-1:0] tlb_idx_t;
    typedef logic [$clog2(`TLB_NWAY)-1:0]             tlb_way_t;
    typedef logic [$clog2(`TLB_NSET)-1:0]             tlb_set_t;

    // one half of a page pair
    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_page_t;

    typedef struct packed {
        vppn_t     vppn;
        ps_t       ps;
        logic      g;
        asid_t     asid;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef struct packed {
        tlb_entry_t body;
        logic       e;  // lives in the valid bit array
    } tlb_wr_port_t;

    typedef struct packed {
        logic  fetch;
        vppn_t vppn;
        logic  odd_page;
        asid_t asid;
    } tlb_search_req_t;

    typedef struct packed {
        logic      found;
        tlb_idx_t  index;
        ps_t       ps;
        tlb_page_t page;
    } tlb_search_rsp_t;

    // invtlb op field
    typedef enum logic [4:0] {
        INV_ALL0      = 5'd0,
        INV_ALL1      = 5'd1,
        INV_GLOBAL    = 5'd2,
        INV_NONGLOBAL = 5'd3,
        INV_ASID      = 5'd4,
        INV_ASID_VA   = 5'd5,
        INV_GA_VA     = 5'd6
    } inv_op_e;

    typedef struct packed {
        logic    en;  // held until stall drops
        inv_op_e op;
        asid_t   asid;
        vppn_t   vpn;
    } tlb_inv_t;

    typedef enum logic [1:0] {
        INV_IDLE,
        INV_SWEEP,
        INV_DONE
    } inv_state_e;

endpackage

/* rtl/tlb_settings.svh */
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

// geometry, both powers of two
`define TLB_NWAY 4
`define TLB_NSET 8

// page size codes
`define TLB_PS_4K 12
`define TLB_PS_2M 21

// lowest vppn bit of a huge page tag, the bit below it picks the odd half
`define TLB_HUGE_LSB (`TLB_PS_2M - `TLB_PS_4K)

// set index is taken from vppn starting here
`define TLB_SET_LSB 8

`endif
